/* lc3b_alu_pipe.f */
hdl/lc3b_pkg.sv
hdl/lc3b_regfile.sv
hdl/decode_stage.sv
hdl/forwarding_unit.sv
hdl/execute_stage.sv
hdl/writeback_stage.sv
hdl/lc3b_alu_pipe.sv
testbench/lc3b_alu_pipe_assertions.sv
testbench/lc3b_alu_pipe_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= lc3b_alu_pipe_tb
RTL_TOP ?= lc3b_alu_pipe
FILELIST ?= lc3b_alu_pipe.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TEST RESULT: FAIL" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* testbench/lc3b_alu_pipe_tb.sv */
`timescale 1ns/1ps

module lc3b_alu_pipe_tb;

	localparam int latency = 3;             // Drive edge to wb outputs.
	localparam int reset_cycles = 3;
	localparam int rand_count = 200;
	localparam int margin = 50;

	localparam logic [2:0] cc_n = 3'b100;
	localparam logic [2:0] cc_z = 3'b010;
	localparam logic [2:0] cc_p = 3'b001;

	typedef struct packed {
		logic valid;
		logic [15:0] instr;
		logic [2:0] dr;
		logic [15:0] data;
		logic [2:0] cc;
	} step_t;

	typedef struct packed {
		logic [31:0] due;                   // Checker cycle of retirement.
		logic from_table;
		logic [15:0] instr;
		logic [2:0] dr;
		logic [15:0] data;
		logic [2:0] cc;
	} pending_t;

	logic clk;
	logic arst_n;
	logic in_valid;
	lc3b_pkg::instr_t in_instr;
	logic wb_valid;
	logic [2:0] wb_dr;
	logic [15:0] wb_data;
	lc3b_pkg::cc_t wb_cc;

	step_t steps [$];
	pending_t pend_q [$];
	logic [15:0] model_regs [8];            // Architectural state at retirement.
	pending_t head;
	logic [2:0] exp_dr;
	logic [15:0] exp_data;
	logic [2:0] exp_cc;
	int cycles = 0;
	int cycle_limit = 1000;
	int errors = 0;
	int checks = 0;
	integer seed;

	lc3b_alu_pipe uut (
		.clk(clk), .arst_n(arst_n),
		.in_valid(in_valid), .in_instr(in_instr),
		.wb_valid(wb_valid), .wb_dr(wb_dr),
		.wb_data(wb_data), .wb_cc(wb_cc)
	);

	initial clk = 1'b0;
	always #10 clk = ~clk;

	function automatic logic [15:0] reg_word(input logic [3:0] op, input logic [2:0] dr,
		input logic [2:0] sr1, input logic [2:0] sr2);
		return {op, dr, sr1, 3'b000, sr2};
	endfunction

	function automatic logic [15:0] imm_word(input logic [3:0] op, input logic [2:0] dr,
		input logic [2:0] sr1, input logic [4:0] imm);
		return {op, dr, sr1, 1'b1, imm};
	endfunction

	function automatic logic [15:0] not_word(input logic [2:0] dr, input logic [2:0] sr1);
		return {lc3b_pkg::op_not, dr, sr1, 6'b111111};
	endfunction

	function automatic logic [15:0] shift_word(input logic [2:0] dr, input logic [2:0] sr1,
		input logic arith, input logic dir, input logic [3:0] amount);
		return {lc3b_pkg::op_shf, dr, sr1, arith, dir, amount};
	endfunction

	function automatic logic [3:0] pick_opcode(input logic [1:0] sel);
		case (sel)
			2'd0: return lc3b_pkg::op_add;
			2'd1: return lc3b_pkg::op_and;
			2'd2: return lc3b_pkg::op_not;
			default: return lc3b_pkg::op_shf;
		endcase
	endfunction

	// ISA result from the model registers, by raw bit position.
	function automatic logic [15:0] reference_result(input logic [15:0] word);
		logic [15:0] a;
		logic [15:0] b;
		a = model_regs[word[8:6]];
		if (word[5])
			b = {{11{word[4]}}, word[4:0]};
		else
			b = model_regs[word[2:0]];
		case (word[15:12])
			lc3b_pkg::op_add: return a + b;
			lc3b_pkg::op_and: return a & b;
			lc3b_pkg::op_not: return ~a;
			default:
			begin
				if (!word[4])
					return a << word[3:0];
				else if (word[5])
					return $signed(a) >>> word[3:0];
				return a >> word[3:0];
			end
		endcase
	endfunction

	function automatic logic [2:0] reference_cc(input logic [15:0] data);
		if (data[15])
			return cc_n;
		else if (data == '0)
			return cc_z;
		return cc_p;
	endfunction

	task automatic add_row(input logic [15:0] word, input logic [2:0] dr,
		input logic [15:0] data, input logic [2:0] cc);
		steps.push_back({1'b1, word, dr, data, cc});
	endtask

	// A bubble carries a real writer word that must not retire.
	task automatic add_bubbles(input int n);
		for (int i = 0; i < n; i++)
			steps.push_back({1'b0, imm_word(lc3b_pkg::op_add, 3'd7, 3'd0, 5'd1), 3'd0, 16'h0, 3'd0});
	endtask

	task automatic build_table();
		add_row(imm_word(lc3b_pkg::op_add, 3'd1, 3'd0, 5'd7), 3'd1, 16'h0007, cc_p);
		add_bubbles(3);
		add_row(imm_word(lc3b_pkg::op_add, 3'd2, 3'd0, 5'b11101), 3'd2, 16'hfffd, cc_n);
		add_bubbles(3);
		add_row(reg_word(lc3b_pkg::op_add, 3'd3, 3'd1, 3'd2), 3'd3, 16'h0004, cc_p);
		add_bubbles(3);
		add_row(reg_word(lc3b_pkg::op_and, 3'd4, 3'd2, 3'd1), 3'd4, 16'h0005, cc_p);
		add_bubbles(3);
		add_row(imm_word(lc3b_pkg::op_and, 3'd5, 3'd1, 5'd0), 3'd5, 16'h0000, cc_z);
		add_bubbles(3);
		add_row(not_word(3'd6, 3'd1), 3'd6, 16'hfff8, cc_n);
		add_bubbles(3);
		add_row(shift_word(3'd7, 3'd1, 1'b0, 1'b0, 4'd4), 3'd7, 16'h0070, cc_p);
		add_bubbles(3);
		add_row(shift_word(3'd5, 3'd2, 1'b0, 1'b1, 4'd4), 3'd5, 16'h0fff, cc_p);
		add_bubbles(3);
		add_row(shift_word(3'd5, 3'd6, 1'b1, 1'b1, 4'd2), 3'd5, 16'hfffe, cc_n);
		add_bubbles(3);
		// Back to back on sr1, then on sr2.
		add_row(imm_word(lc3b_pkg::op_add, 3'd1, 3'd1, 5'd1), 3'd1, 16'h0008, cc_p);
		add_row(imm_word(lc3b_pkg::op_add, 3'd3, 3'd1, 5'd2), 3'd3, 16'h000a, cc_p);
		add_row(imm_word(lc3b_pkg::op_add, 3'd2, 3'd0, 5'd5), 3'd2, 16'h0005, cc_p);
		add_row(reg_word(lc3b_pkg::op_and, 3'd4, 3'd7, 3'd2), 3'd4, 16'h0000, cc_z);
		add_bubbles(3);
		// Distance two via MEM/WB, distance three via the bypass.
		add_row(imm_word(lc3b_pkg::op_add, 3'd6, 3'd0, 5'd12), 3'd6, 16'h000c, cc_p);
		add_row(not_word(3'd7, 3'd0), 3'd7, 16'hffff, cc_n);
		add_row(reg_word(lc3b_pkg::op_add, 3'd5, 3'd6, 3'd1), 3'd5, 16'h0014, cc_p);
		add_row(imm_word(lc3b_pkg::op_add, 3'd3, 3'd0, 5'b11111), 3'd3, 16'hffff, cc_n);
		add_row(imm_word(lc3b_pkg::op_and, 3'd4, 3'd1, 5'd15), 3'd4, 16'h0008, cc_p);
		add_row(imm_word(lc3b_pkg::op_add, 3'd2, 3'd0, 5'd1), 3'd2, 16'h0001, cc_p);
		add_row(reg_word(lc3b_pkg::op_and, 3'd4, 3'd3, 3'd2), 3'd4, 16'h0001, cc_p);
		add_bubbles(3);
		// Two writers of R1, the younger one wins.
		add_row(imm_word(lc3b_pkg::op_add, 3'd1, 3'd0, 5'd3), 3'd1, 16'h0003, cc_p);
		add_row(imm_word(lc3b_pkg::op_add, 3'd1, 3'd0, 5'd9), 3'd1, 16'h0009, cc_p);
		add_row(reg_word(lc3b_pkg::op_add, 3'd2, 3'd1, 3'd1), 3'd2, 16'h0012, cc_p);
		// Low imm5 bits name R3 while it is in flight.
		add_row(imm_word(lc3b_pkg::op_add, 3'd3, 3'd0, 5'd6), 3'd3, 16'h0006, cc_p);
		add_row(imm_word(lc3b_pkg::op_add, 3'd4, 3'd1, 5'd3), 3'd4, 16'h000c, cc_p);
		add_bubbles(4);
	endtask

	task automatic issue_slot(input logic valid, input logic [15:0] word,
		input logic from_table, input logic [2:0] dr, input logic [15:0] data,
		input logic [2:0] cc);
		pending_t entry;
		@(posedge clk);
		in_valid <= valid;
		in_instr <= word;
		if (valid)
		begin
			entry.due = cycles + latency;
			entry.from_table = from_table;
			entry.instr = word;
			entry.dr = dr;
			entry.data = data;
			entry.cc = cc;
			pend_q.push_back(entry);
		end
	endtask

	// Outputs settle after the rising edge, so they are sampled here.
	always @(negedge clk)
	begin
		if (wb_valid)
		begin
			if (pend_q.size() == 0)
			begin
				$display("Error at %0t: wb_valid is set with no instruction in flight", $time);
				errors++;
			end
			else
			begin
				head = pend_q.pop_front();
				if (head.from_table)
				begin
					exp_dr = head.dr;
					exp_data = head.data;
					exp_cc = head.cc;
				end
				else
				begin
					exp_dr = head.instr[11:9];
					exp_data = reference_result(head.instr);
					exp_cc = reference_cc(exp_data);
				end
				checks++;
				if (head.due != cycles)
				begin
					$display("FAILED at %0t: latency, due at cycle %0d", $time, head.due);
					errors++;
				end
				if (wb_dr !== exp_dr)
				begin
					$display("FAILED at %0t: wb_dr is %0d, expected %0d", $time, wb_dr, exp_dr);
					errors++;
				end
				if (wb_data !== exp_data)
				begin
					$display("FAILED at %0t: wb_data is %h, expected %h", $time, wb_data, exp_data);
					errors++;
				end
				if (wb_cc !== exp_cc)
				begin
					$display("FAILED at %0t: wb_cc is %b, expected %b", $time, wb_cc, exp_cc);
					errors++;
				end
				model_regs[exp_dr] = exp_data;    // Retire in program order.
			end
		end
		else if ((pend_q.size() != 0) && (pend_q[0].due <= cycles))
		begin
			$display("Error at %0t: instruction due at cycle %0d never retired", $time,
				pend_q[0].due);
			errors++;
			head = pend_q.pop_front();
		end
		cycles++;
		if (cycles >= cycle_limit)
		begin
			$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	initial
	begin
		int r;
		logic [15:0] word;
		arst_n = 1'b0;
		in_valid = 1'b0;
		in_instr = '0;
		seed = 82;
		foreach (model_regs[i])
			model_regs[i] = '0;
		build_table();
		cycle_limit = reset_cycles + steps.size() + 2 * rand_count + latency + 3 + margin;
		repeat (reset_cycles) @(posedge clk);
		arst_n <= 1'b1;

		foreach (steps[i])
			issue_slot(steps[i].valid, steps[i].instr, 1'b1, steps[i].dr, steps[i].data,
				steps[i].cc);

		// Random mix with about one bubble in four slots.
		for (int i = 0; i < rand_count; i++)
		begin
			r = $random(seed);
			if (r[1:0] == 2'b00)
				issue_slot(1'b0, r[31:16], 1'b0, 3'd0, 16'h0, 3'd0);
			r = $random(seed);
			word = {pick_opcode(r[13:12]), r[11:0]};
			issue_slot(1'b1, word, 1'b0, 3'd0, 16'h0, 3'd0);
		end

		@(posedge clk);
		in_valid <= 1'b0;
		while (pend_q.size() != 0)
			@(posedge clk);
		repeat (3) @(posedge clk);              // Catch a stray wb_valid.

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule : lc3b_alu_pipe_tb

/* testbench/lc3b_alu_pipe_assertions.sv */
`timescale 1ns/1ps

module lc3b_alu_pipe_assertions
(
	input logic clk,
	input logic arst_n,
	input lc3b_pkg::id_ex_t id_ex,
	input logic sr2_fwd,
	input logic sr1_fwd_src,
	input lc3b_pkg::ex_mem_t ex_mem,
	input lc3b_pkg::mem_wb_t mem_wb
);

	logic [3:0] opcode;
	logic sr1_both_hit;

	assign opcode = id_ex.instr.rform.opcode;

	// Both older writers target the executing sr1.
	assign sr1_both_hit = id_ex.valid && ex_mem.valid && mem_wb.valid
		&& (ex_mem.dr == id_ex.instr.rform.sr1) && (mem_wb.dr == id_ex.instr.rform.sr1);

	ex_mem_idle_in_reset: assert property (@(posedge clk) !arst_n |-> !ex_mem.valid)
		else $error("EX/MEM valid is set while reset is active");

	no_sr2_fwd_unary: assert property (@(posedge clk) disable iff (!arst_n)
		((opcode == lc3b_pkg::op_not) || (opcode == lc3b_pkg::op_shf)) |-> !sr2_fwd)
		else $error("sr2 forwarding enabled for NOT or SHF");

	newest_writer_wins: assert property (@(posedge clk) disable iff (!arst_n)
		sr1_both_hit |-> !sr1_fwd_src)
		else $error("sr1 forwarded from MEM/WB while EX/MEM also matches");

endmodule : lc3b_alu_pipe_assertions

bind execute_stage lc3b_alu_pipe_assertions checks (
	.clk(clk), .arst_n(arst_n), .id_ex(id_ex), .sr2_fwd(sr2_fwd),
	.sr1_fwd_src(sr1_fwd_src), .ex_mem(ex_mem), .mem_wb(mem_wb)
);

/* hdl/lc3b_alu_pipe.sv */
`timescale 1ns/1ps

module lc3b_alu_pipe
(
	input logic clk,
	input logic arst_n,
	input logic in_valid,
	input lc3b_pkg::instr_t in_instr,

	output logic wb_valid,
	output logic [lc3b_pkg::reg_addr_w-1:0] wb_dr,
	output logic [lc3b_pkg::word_w-1:0] wb_data,
	output lc3b_pkg::cc_t wb_cc
);

	logic [lc3b_pkg::reg_addr_w-1:0] rd_addr1, rd_addr2;
	logic [lc3b_pkg::word_w-1:0] rd_data1, rd_data2;
	logic wr_en;
	logic [lc3b_pkg::reg_addr_w-1:0] wr_addr;
	logic [lc3b_pkg::word_w-1:0] wr_data;

	lc3b_pkg::id_ex_t id_ex;
	lc3b_pkg::ex_mem_t ex_mem;
	lc3b_pkg::mem_wb_t mem_wb;

	logic sr1_fwd, sr1_fwd_src;
	logic sr2_fwd, sr2_fwd_src;

	lc3b_regfile regfile (
		.clk(clk), .arst_n(arst_n),
		.rd_addr1(rd_addr1), .rd_addr2(rd_addr2),
		.wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
		.rd_data1(rd_data1), .rd_data2(rd_data2)
	);

	decode_stage decode (
		.clk(clk), .arst_n(arst_n),
		.in_valid(in_valid), .in_instr(in_instr),
		.rd_data1(rd_data1), .rd_data2(rd_data2),
		.rd_addr1(rd_addr1), .rd_addr2(rd_addr2),
		.id_ex(id_ex)
	);

	forwarding_unit fwd (
		.id_ex(id_ex), .ex_mem(ex_mem), .mem_wb(mem_wb),
		.sr1_fwd(sr1_fwd), .sr1_fwd_src(sr1_fwd_src),
		.sr2_fwd(sr2_fwd), .sr2_fwd_src(sr2_fwd_src)
	);

	execute_stage execute (
		.clk(clk), .arst_n(arst_n), .id_ex(id_ex),
		.sr1_fwd(sr1_fwd), .sr1_fwd_src(sr1_fwd_src),
		.sr2_fwd(sr2_fwd), .sr2_fwd_src(sr2_fwd_src),
		.mem_wb(mem_wb), .ex_mem(ex_mem)
	);

	writeback_stage writeback (
		.clk(clk), .arst_n(arst_n), .ex_mem(ex_mem),
		.mem_wb(mem_wb), .wr_en(wr_en), .wr_addr(wr_addr),
		.wr_data(wr_data), .wb_cc(wb_cc)
	);

	// Retiring instruction straight from MEM/WB.
	assign wb_valid = mem_wb.valid;
	assign wb_dr = mem_wb.dr;
	assign wb_data = mem_wb.result;

endmodule : lc3b_alu_pipe

/* hdl/writeback_stage.sv */
`timescale 1ns/1ps

module writeback_stage
(
	input logic clk,
	input logic arst_n,
	input lc3b_pkg::ex_mem_t ex_mem,

	output lc3b_pkg::mem_wb_t mem_wb,
	output logic wr_en,
	output logic [lc3b_pkg::reg_addr_w-1:0] wr_addr,
	output logic [lc3b_pkg::word_w-1:0] wr_data,
	output lc3b_pkg::cc_t wb_cc
);

	logic is_neg;
	logic is_zero;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			mem_wb <= '0;
		else
			mem_wb <= ex_mem;
	end

	// Register file takes the result on the next edge.
	assign wr_en = mem_wb.valid;
	assign wr_addr = mem_wb.dr;
	assign wr_data = mem_wb.result;

	assign is_neg = mem_wb.result[lc3b_pkg::word_w-1];
	assign is_zero = (mem_wb.result == '0);

	// Codes only mean something for a retiring instruction.
	always_comb
	begin
		wb_cc = '0;
		if (mem_wb.valid)
		begin
			wb_cc.n = is_neg;
			wb_cc.z = is_zero;
			wb_cc.p = !is_neg && !is_zero;
		end
	end

endmodule : writeback_stage

/* hdl/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage
(
	input logic clk,
	input logic arst_n,
	input lc3b_pkg::id_ex_t id_ex,
	input logic sr1_fwd,
	input logic sr1_fwd_src,
	input logic sr2_fwd,
	input logic sr2_fwd_src,
	input lc3b_pkg::mem_wb_t mem_wb,

	output lc3b_pkg::ex_mem_t ex_mem
);

	logic [lc3b_pkg::word_w-1:0] src_a;
	logic [lc3b_pkg::word_w-1:0] src_b;
	logic [lc3b_pkg::word_w-1:0] imm_ext;
	logic [lc3b_pkg::word_w-1:0] opnd_b;
	logic [lc3b_pkg::word_w-1:0] alu_result;
	lc3b_pkg::sform_t shf;

	// Register value or one of the two forwarded results.
	function automatic logic [lc3b_pkg::word_w-1:0] pick_operand
	(
		input logic fwd,
		input logic fwd_src,
		input logic [lc3b_pkg::word_w-1:0] reg_val,
		input logic [lc3b_pkg::word_w-1:0] ex_val,
		input logic [lc3b_pkg::word_w-1:0] wb_val
	);
		if (!fwd)
			return reg_val;
		return fwd_src ? wb_val : ex_val;
	endfunction

	assign src_a = pick_operand(sr1_fwd, sr1_fwd_src, id_ex.sr1_val,
		ex_mem.result, mem_wb.result);
	assign src_b = pick_operand(sr2_fwd, sr2_fwd_src, id_ex.sr2_val,
		ex_mem.result, mem_wb.result);

	assign imm_ext = {{(lc3b_pkg::word_w-5){id_ex.instr.iform.imm5[4]}},
		id_ex.instr.iform.imm5};
	assign opnd_b = id_ex.instr.iform.steer ? imm_ext : src_b;
	assign shf = id_ex.instr.sform;

	always_comb
	begin
		case (id_ex.instr.rform.opcode)
			lc3b_pkg::op_add: alu_result = src_a + opnd_b;
			lc3b_pkg::op_and: alu_result = src_a & opnd_b;
			lc3b_pkg::op_not: alu_result = ~src_a;
			lc3b_pkg::op_shf:
			begin
				if (!shf.dir)
					alu_result = src_a << shf.amount;
				else if (shf.arith)
					alu_result = $signed(src_a) >>> shf.amount;
				else
					alu_result = src_a >> shf.amount;
			end
			default: alu_result = '0;       // Not an operate opcode.
		endcase
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			ex_mem <= '0;
		end
		else
		begin
			ex_mem.valid <= id_ex.valid;
			ex_mem.dr <= id_ex.instr.rform.dr;
			ex_mem.result <= alu_result;
		end
	end

endmodule : execute_stage

/* hdl/forwarding_unit.sv */
`timescale 1ns/1ps

module forwarding_unit
(
	input lc3b_pkg::id_ex_t id_ex,
	input lc3b_pkg::ex_mem_t ex_mem,
	input lc3b_pkg::mem_wb_t mem_wb,

	output logic sr1_fwd,
	output logic sr1_fwd_src,             // 0 is EX/MEM, 1 is MEM/WB.
	output logic sr2_fwd,
	output logic sr2_fwd_src
);

	logic [3:0] opcode;
	logic uses_sr2;
	logic sr1_hit_ex, sr1_hit_wb;
	logic sr2_hit_ex, sr2_hit_wb;

	assign opcode = id_ex.instr.rform.opcode;

	// Only register-form ADD and AND read sr2.
	assign uses_sr2 = ((opcode == lc3b_pkg::op_add) || (opcode == lc3b_pkg::op_and))
		&& !id_ex.instr.rform.steer;

	// Every operate opcode writes dr.
	assign sr1_hit_ex = ex_mem.valid && (ex_mem.dr == id_ex.instr.rform.sr1);
	assign sr1_hit_wb = mem_wb.valid && (mem_wb.dr == id_ex.instr.rform.sr1);
	assign sr2_hit_ex = ex_mem.valid && (ex_mem.dr == id_ex.instr.rform.sr2);
	assign sr2_hit_wb = mem_wb.valid && (mem_wb.dr == id_ex.instr.rform.sr2);

	always_comb
	begin
		sr1_fwd = 1'b0;
		sr1_fwd_src = 1'b0;
		sr2_fwd = 1'b0;
		sr2_fwd_src = 1'b0;

		if (id_ex.valid)
		begin
			sr1_fwd = sr1_hit_ex || sr1_hit_wb;
			sr1_fwd_src = !sr1_hit_ex;       // Younger writer wins.
			if (uses_sr2)
			begin
				sr2_fwd = sr2_hit_ex || sr2_hit_wb;
				sr2_fwd_src = !sr2_hit_ex;
			end
		end
	end

endmodule : forwarding_unit

/* hdl/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage
(
	input logic clk,
	input logic arst_n,
	input logic in_valid,
	input lc3b_pkg::instr_t in_instr,
	input logic [lc3b_pkg::word_w-1:0] rd_data1,
	input logic [lc3b_pkg::word_w-1:0] rd_data2,

	output logic [lc3b_pkg::reg_addr_w-1:0] rd_addr1,
	output logic [lc3b_pkg::reg_addr_w-1:0] rd_addr2,
	output lc3b_pkg::id_ex_t id_ex
);

	lc3b_pkg::id_ex_t id_ex_next;

	// Source fields sit in the same place in every form.
	assign rd_addr1 = in_instr.rform.sr1;
	assign rd_addr2 = in_instr.rform.sr2;

	always_comb
	begin
		id_ex_next.valid = in_valid;
		id_ex_next.instr = in_instr;
		id_ex_next.sr1_val = rd_data1;
		id_ex_next.sr2_val = rd_data2;   // Unused by immediate and shift forms.
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			id_ex <= '0;
		end
		else if (in_valid)
		begin
			id_ex <= id_ex_next;
		end
		else
		begin
			id_ex.valid <= 1'b0;             // Bubble.
		end
	end

endmodule : decode_stage

/* hdl/lc3b_regfile.sv */
`timescale 1ns/1ps

module lc3b_regfile
(
	input logic clk,
	input logic arst_n,
	input logic [lc3b_pkg::reg_addr_w-1:0] rd_addr1,
	input logic [lc3b_pkg::reg_addr_w-1:0] rd_addr2,
	input logic wr_en,
	input logic [lc3b_pkg::reg_addr_w-1:0] wr_addr,
	input logic [lc3b_pkg::word_w-1:0] wr_data,

	output logic [lc3b_pkg::word_w-1:0] rd_data1,
	output logic [lc3b_pkg::word_w-1:0] rd_data2
);

	localparam int num_regs = 2 ** lc3b_pkg::reg_addr_w;

	logic [lc3b_pkg::word_w-1:0] regs [num_regs];

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			for (int i = 0; i < num_regs; i++)
				regs[i] <= '0;
		end
		else if (wr_en)
		begin
			regs[wr_addr] <= wr_data;
		end
	end

	// Same-cycle write shows through to the readers.
	always_comb
	begin
		if (wr_en && (wr_addr == rd_addr1))
			rd_data1 = wr_data;
		else
			rd_data1 = regs[rd_addr1];

		if (wr_en && (wr_addr == rd_addr2))
			rd_data2 = wr_data;
		else
			rd_data2 = regs[rd_addr2];
	end

endmodule : lc3b_regfile

/* hdl/lc3b_pkg.sv */
package lc3b_pkg;

	localparam int reg_addr_w = 3;
	localparam int word_w = 16;

	// LC-3b operate opcodes.
	localparam logic [3:0] op_add = 4'b0001;
	localparam logic [3:0] op_and = 4'b0101;
	localparam logic [3:0] op_not = 4'b1001;
	localparam logic [3:0] op_shf = 4'b1101;

	typedef struct packed {
		logic [3:0] opcode;
		logic [reg_addr_w-1:0] dr;
		logic [reg_addr_w-1:0] sr1;
		logic steer;                     // Clear for register form.
		logic [1:0] unused;
		logic [reg_addr_w-1:0] sr2;
	} rform_t;

	typedef struct packed {
		logic [3:0] opcode;
		logic [reg_addr_w-1:0] dr;
		logic [reg_addr_w-1:0] sr1;
		logic steer;                     // Set for immediate form.
		logic [4:0] imm5;
	} iform_t;

	typedef struct packed {
		logic [3:0] opcode;
		logic [reg_addr_w-1:0] dr;
		logic [reg_addr_w-1:0] sr1;
		logic arith;                     // Sign fill on right shift.
		logic dir;                       // Zero shifts left.
		logic [3:0] amount;
	} sform_t;

	// One instruction word seen three ways.
	typedef union packed {
		rform_t rform;
		iform_t iform;
		sform_t sform;
	} instr_t;

	typedef struct packed {
		logic valid;
		instr_t instr;
		logic [word_w-1:0] sr1_val;
		logic [word_w-1:0] sr2_val;
	} id_ex_t;

	typedef struct packed {
		logic valid;
		logic [reg_addr_w-1:0] dr;
		logic [word_w-1:0] result;
	} ex_mem_t;

	typedef ex_mem_t mem_wb_t;        // Same fields one stage later.

	typedef struct packed {
		logic n;
		logic z;
		logic p;
	} cc_t;

endpackage : lc3b_pkg
